// File: source/axi3_conv_pkg.sv
`default_nettype none

package axi3_conv_pkg;

  localparam int ID_W   = 4;
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int STRB_W = DATA_W / 8;

  // AXI3 bursts stop at 16 beats
  localparam int AXI3_MAX_BEATS = 16;

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;
  localparam logic [1:0] RESP_DECERR = 2'b11;

  typedef struct packed {
    logic [ID_W-1:0]   id;
    logic [ADDR_W-1:0] addr;
    logic [7:0]        len;
    logic [2:0]        size;
  } aw4_t;

  typedef struct packed {
    logic [ID_W-1:0]   id;
    logic [ADDR_W-1:0] addr;
    logic [3:0]        len;
    logic [2:0]        size;
  } aw3_t;

  // One per AXI3 piece, consumed by the W converter
  typedef struct packed {
    logic [ID_W-1:0] id;
    logic [3:0]      len;
  } w_cmd_t;

  // last marks the final piece of an AXI4 burst
  typedef struct packed {
    logic [ID_W-1:0] id;
    logic            last;
  } b_cmd_t;

  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic [STRB_W-1:0] strb;
    logic              last;
  } w4_beat_t;

  typedef struct packed {
    logic [ID_W-1:0]   id;
    logic [DATA_W-1:0] data;
    logic [STRB_W-1:0] strb;
    logic              last;
  } w3_beat_t;

  typedef struct packed {
    logic [ID_W-1:0] id;
    logic [1:0]      resp;
  } b_resp_t;

endpackage

`default_nettype wire

// File: source/aw_split_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module aw_split_ctrl
  import axi3_conv_pkg::*;
(
  input  wire        ACLK,
  input  wire        ARESET,
  input  wire aw4_t  s_aw,
  input  wire        s_aw_valid,
  output logic       s_aw_ready,
  output aw3_t       m_aw,
  output logic       m_aw_valid,
  input  wire        m_aw_ready,
  output w_cmd_t     wcmd,
  output logic       wcmd_push,
  input  wire        wcmd_full,
  output b_cmd_t     bcmd,
  output logic       bcmd_push,
  input  wire        bcmd_full
);

  logic [3:0]        piece_cnt;
  logic [7:0]        beats_done;
  logic [7:0]        rem_len;
  logic              last_piece;
  logic [3:0]        piece_len;
  logic [ADDR_W-1:0] piece_offset;
  logic              issue;

  // Beats already covered by earlier pieces
  assign beats_done = 8'(piece_cnt * AXI3_MAX_BEATS);
  assign rem_len    = s_aw.len - beats_done;   // len-1 encoding kept
  assign last_piece = (rem_len < 8'(AXI3_MAX_BEATS));
  assign piece_len  = last_piece ? rem_len[3:0] : 4'(AXI3_MAX_BEATS - 1);

  // Byte offset of this piece, scaled by beat size
  assign piece_offset = ADDR_W'(beats_done) << s_aw.size;

  // Both command FIFOs need room before a piece goes out
  assign m_aw_valid = s_aw_valid & ~wcmd_full & ~bcmd_full;
  assign issue      = m_aw_valid & m_aw_ready;

  assign m_aw.id   = s_aw.id;
  assign m_aw.addr = s_aw.addr + piece_offset;
  assign m_aw.len  = piece_len;
  assign m_aw.size = s_aw.size;

  assign wcmd.id   = s_aw.id;
  assign wcmd.len  = piece_len;
  assign wcmd_push = issue;

  assign bcmd.id   = s_aw.id;
  assign bcmd.last = last_piece;
  assign bcmd_push = issue;

  // AXI4 request retires with its final piece
  assign s_aw_ready = issue & last_piece;

  always_ff @(posedge ACLK) begin
    if (ARESET) begin
      piece_cnt <= '0;
    end else if (issue) begin
      if (last_piece) begin
        piece_cnt <= '0;
      end else begin
        piece_cnt <= piece_cnt + 4'd1;
      end
    end
  end

endmodule

`default_nettype wire

// File: source/cmd_fifo.sv
`timescale 1ns/1ps
`default_nettype none

// First-word-fall-through, DEPTH must be a power of two (2 or more)
module cmd_fifo #(
  parameter int  DEPTH = 4,
  parameter type T     = logic
) (
  input  wire   ACLK,
  input  wire   ARESET,
  input  wire T wr_data,
  input  wire   push,
  output logic  full,
  output T      rd_data,
  output logic  valid,
  input  wire   pop
);

  localparam int PTR_W = $clog2(DEPTH);

  T               mem [DEPTH];
  logic [PTR_W:0] wr_ptr;   // MSB is the wrap bit
  logic [PTR_W:0] rd_ptr;
  logic           do_push;
  logic           do_pop;

  assign full  = (wr_ptr[PTR_W] != rd_ptr[PTR_W]) &&
                 (wr_ptr[PTR_W-1:0] == rd_ptr[PTR_W-1:0]);
  assign valid = (wr_ptr != rd_ptr);

  assign do_push = push & ~full;
  assign do_pop  = pop & valid;

  assign rd_data = mem[rd_ptr[PTR_W-1:0]];

  always_ff @(posedge ACLK) begin
    if (ARESET) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (do_push) wr_ptr <= wr_ptr + 1'b1;
      if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
    end
  end

  // Storage
  always_ff @(posedge ACLK) begin
    if (do_push) begin
      mem[wr_ptr[PTR_W-1:0]] <= wr_data;
    end
  end

endmodule

`default_nettype wire

// File: source/w_axi3_conv.sv
`timescale 1ns/1ps
`default_nettype none

module w_axi3_conv
  import axi3_conv_pkg::*;
(
  input  wire           ACLK,
  input  wire           ARESET,
  input  wire w_cmd_t   cmd,
  input  wire           cmd_valid,
  output logic          cmd_ready,
  input  wire w4_beat_t s_w,
  input  wire           s_w_valid,
  output logic          s_w_ready,
  output w3_beat_t      m_w,
  output logic          m_w_valid,
  input  wire           m_w_ready
);

  logic       first_beat;
  logic [3:0] cnt_q;
  logic [3:0] cnt;
  logic       last_beat;
  logic       stall;
  logic       beat_hs;

  // Fresh length from the command on the first beat of a piece
  assign cnt       = first_beat ? cmd.len : cnt_q;
  assign last_beat = (cnt == 4'd0);

  assign m_w_valid = s_w_valid & cmd_valid;
  assign stall     = m_w_valid & ~m_w_ready;
  assign s_w_ready = s_w_valid & cmd_valid & ~stall;
  assign beat_hs   = m_w_valid & m_w_ready;
  assign cmd_ready = beat_hs & last_beat;   // pop after the piece's last beat

  // Incoming last is dropped, AXI3 last comes from the count
  assign m_w.id   = cmd.id;
  assign m_w.data = s_w.data;
  assign m_w.strb = s_w.strb;
  assign m_w.last = last_beat;

  always_ff @(posedge ACLK) begin
    if (ARESET) begin
      first_beat <= 1'b1;
      cnt_q      <= '0;
    end else if (beat_hs) begin
      first_beat <= last_beat;
      cnt_q      <= cnt - 4'd1;
    end
  end

endmodule

`default_nettype wire

// File: source/b_merge.sv
`timescale 1ns/1ps
`default_nettype none

module b_merge
  import axi3_conv_pkg::*;
(
  input  wire          ACLK,
  input  wire          ARESET,
  input  wire b_cmd_t  bcmd,
  input  wire          bcmd_valid,
  output logic         bcmd_pop,
  input  wire b_resp_t m_b,
  input  wire          m_b_valid,
  output logic         m_b_ready,
  output b_resp_t      s_b,
  output logic         s_b_valid,
  input  wire          s_b_ready
);

  logic [1:0] worst_q;
  logic [1:0] merged;
  logic       b_hs;

  // Higher code is the worse one
  assign merged = (m_b.resp > worst_q) ? m_b.resp : worst_q;

  // Non-last pieces are swallowed, the last one waits for the master
  assign m_b_ready = bcmd_valid & (~bcmd.last | s_b_ready);
  assign s_b_valid = m_b_valid & bcmd_valid & bcmd.last;

  assign s_b.id   = bcmd.id;
  assign s_b.resp = merged;

  assign b_hs     = m_b_valid & m_b_ready;
  assign bcmd_pop = b_hs;

  always_ff @(posedge ACLK) begin
    if (ARESET) begin
      worst_q <= RESP_OKAY;
    end else if (b_hs) begin
      if (bcmd.last) begin
        worst_q <= RESP_OKAY;   // next AXI4 burst starts clean
      end else begin
        worst_q <= merged;
      end
    end
  end

endmodule

`default_nettype wire

// File: source/axi3_write_conv.sv
`timescale 1ns/1ps
`default_nettype none

module axi3_write_conv
  import axi3_conv_pkg::*;
#(
  parameter int CMD_DEPTH = 4
) (
  input  wire           ACLK,
  input  wire           ARESET,
  input  wire aw4_t     s_aw,
  input  wire           s_aw_valid,
  output logic          s_aw_ready,
  output aw3_t          m_aw,
  output logic          m_aw_valid,
  input  wire           m_aw_ready,
  input  wire w4_beat_t s_w,
  input  wire           s_w_valid,
  output logic          s_w_ready,
  output w3_beat_t      m_w,
  output logic          m_w_valid,
  input  wire           m_w_ready,
  input  wire b_resp_t  m_b,
  input  wire           m_b_valid,
  output logic          m_b_ready,
  output b_resp_t       s_b,
  output logic          s_b_valid,
  input  wire           s_b_ready
);

  w_cmd_t wcmd_in;
  w_cmd_t wcmd_head;
  logic   wcmd_push;
  logic   wcmd_full;
  logic   wcmd_valid;
  logic   wcmd_pop;

  b_cmd_t bcmd_in;
  b_cmd_t bcmd_head;
  logic   bcmd_push;
  logic   bcmd_full;
  logic   bcmd_valid;
  logic   bcmd_pop;

  aw_split_ctrl u_ctrl (
    .ACLK       (ACLK),       .ARESET     (ARESET),
    .s_aw       (s_aw),       .s_aw_valid (s_aw_valid), .s_aw_ready (s_aw_ready),
    .m_aw       (m_aw),       .m_aw_valid (m_aw_valid), .m_aw_ready (m_aw_ready),
    .wcmd       (wcmd_in),    .wcmd_push  (wcmd_push),  .wcmd_full  (wcmd_full),
    .bcmd       (bcmd_in),    .bcmd_push  (bcmd_push),  .bcmd_full  (bcmd_full)
  );

  cmd_fifo #(.DEPTH(CMD_DEPTH), .T(w_cmd_t)) u_wcmd_fifo (
    .ACLK    (ACLK),      .ARESET (ARESET),
    .wr_data (wcmd_in),   .push   (wcmd_push),  .full (wcmd_full),
    .rd_data (wcmd_head), .valid  (wcmd_valid), .pop  (wcmd_pop)
  );

  cmd_fifo #(.DEPTH(CMD_DEPTH), .T(b_cmd_t)) u_bcmd_fifo (
    .ACLK    (ACLK),      .ARESET (ARESET),
    .wr_data (bcmd_in),   .push   (bcmd_push),  .full (bcmd_full),
    .rd_data (bcmd_head), .valid  (bcmd_valid), .pop  (bcmd_pop)
  );

  w_axi3_conv u_w_conv (
    .ACLK      (ACLK),      .ARESET    (ARESET),
    .cmd       (wcmd_head), .cmd_valid (wcmd_valid), .cmd_ready (wcmd_pop),
    .s_w       (s_w),       .s_w_valid (s_w_valid),  .s_w_ready (s_w_ready),
    .m_w       (m_w),       .m_w_valid (m_w_valid),  .m_w_ready (m_w_ready)
  );

  b_merge u_b_merge (
    .ACLK       (ACLK),      .ARESET     (ARESET),
    .bcmd       (bcmd_head), .bcmd_valid (bcmd_valid), .bcmd_pop  (bcmd_pop),
    .m_b        (m_b),       .m_b_valid  (m_b_valid),  .m_b_ready (m_b_ready),
    .s_b        (s_b),       .s_b_valid  (s_b_valid),  .s_b_ready (s_b_ready)
  );

endmodule

`default_nettype wire

// File: verif/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
  output logic ACLK,
  output logic ARESET
);

  initial ACLK = 1'b0;
  always #5 ACLK = ~ACLK;   // 10 ns period

  initial begin
    ARESET = 1'b1;
    repeat (10) @(posedge ACLK);
    @(negedge ACLK);
    ARESET = 1'b0;
  end

endmodule

`default_nettype wire

// File: verif/axi3_write_conv_assert.sv
`timescale 1ns/1ps
`default_nettype none

module axi3_write_conv_assert
  import axi3_conv_pkg::*;
(
  input wire           ACLK,
  input wire           ARESET,
  input wire           s_aw_ready,
  input wire aw3_t     m_aw,
  input wire           m_aw_valid,
  input wire           m_aw_ready,
  input wire w3_beat_t m_w,
  input wire           m_w_valid,
  input wire           m_w_ready,
  input wire b_resp_t  s_b,
  input wire           s_b_valid,
  input wire           s_b_ready
);

  aw_hold: assert property (@(posedge ACLK) disable iff (ARESET)
    m_aw_valid && !m_aw_ready |=> m_aw_valid && $stable(m_aw))
    else $error("m_aw dropped or changed before m_aw_ready");

  w_hold: assert property (@(posedge ACLK) disable iff (ARESET)
    m_w_valid && !m_w_ready |=> m_w_valid && $stable(m_w))
    else $error("m_w dropped or changed before m_w_ready");

  b_hold: assert property (@(posedge ACLK) disable iff (ARESET)
    s_b_valid && !s_b_ready |=> s_b_valid && $stable(s_b))
    else $error("s_b dropped or changed before s_b_ready");

  // Next piece of a held request starts 16 beats further on
  aw_next_piece: assert property (@(posedge ACLK) disable iff (ARESET)
    m_aw_valid && m_aw_ready && !s_aw_ready |=>
      m_aw.id == $past(m_aw.id) &&
      m_aw.addr == $past(m_aw.addr) + (ADDR_W'(AXI3_MAX_BEATS) << m_aw.size))
    else $error("AXI3 piece does not continue the held AXI4 request");

endmodule

bind axi3_write_conv axi3_write_conv_assert u_assert (
  .ACLK       (ACLK),       .ARESET     (ARESET),
  .s_aw_ready (s_aw_ready),
  .m_aw       (m_aw),       .m_aw_valid (m_aw_valid), .m_aw_ready (m_aw_ready),
  .m_w        (m_w),        .m_w_valid  (m_w_valid),  .m_w_ready  (m_w_ready),
  .s_b        (s_b),        .s_b_valid  (s_b_valid),  .s_b_ready  (s_b_ready)
);

`default_nettype wire

// File: verif/tb_axi3_write_conv.sv
`timescale 1ns/1ps
`default_nettype none

module tb_axi3_write_conv
  import axi3_conv_pkg::*;
;

  localparam int N_BURSTS = 24;

  logic     ACLK;
  logic     ARESET;
  aw4_t     s_aw;
  logic     s_aw_valid;
  logic     s_aw_ready;
  aw3_t     m_aw;
  logic     m_aw_valid;
  logic     m_aw_ready;
  w4_beat_t s_w;
  logic     s_w_valid;
  logic     s_w_ready;
  w3_beat_t m_w;
  logic     m_w_valid;
  logic     m_w_ready;
  b_resp_t  m_b;
  logic     m_b_valid;
  logic     m_b_ready;
  b_resp_t  s_b;
  logic     s_b_valid;
  logic     s_b_ready;

  aw4_t       aw_q[$];
  w4_beat_t   w_q[$];
  aw3_t       exp_aw[$];
  w3_beat_t   exp_w[$];
  b_resp_t    exp_b[$];
  logic [1:0] slave_codes[$];
  b_resp_t    b_pend[$];
  b_resp_t    slave_b;

  logic [31:0] lfsr_state;
  logic        drive_en;
  int          wlast_seen;
  int          b_sent;
  int          cycle_cnt;
  int          cycle_limit;
  int          aw_errors;
  int          w_errors;
  int          b_errors;
  int          other_errors;

  tb_clock_gen u_clk (.ACLK(ACLK), .ARESET(ARESET));

  axi3_write_conv #(.CMD_DEPTH(2)) u_axi3_write_conv (.*);

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = {lfsr_state[30:0],
                    lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
      r = {r[30:0], lfsr_state[0]};
    end
    return r;
  endfunction

  function automatic logic wlast_at(input int beat, input int len);
    return (beat % AXI3_MAX_BEATS == AXI3_MAX_BEATS - 1) || (beat == len);
  endfunction

  // Expected AXI3 pieces and merged response of one AXI4 burst
  function automatic void build_expected(input aw4_t a, input logic [1:0] codes [16]);
    int      n_pieces;
    aw3_t    p;
    b_resp_t b;
    n_pieces = int'(a.len) / AXI3_MAX_BEATS + 1;
    b.id     = a.id;
    b.resp   = RESP_OKAY;
    for (int i = 0; i < n_pieces; i++) begin
      p.id   = a.id;
      p.addr = a.addr + ADDR_W'(i * AXI3_MAX_BEATS * (1 << a.size));
      p.len  = (i == n_pieces - 1) ? 4'(int'(a.len) % AXI3_MAX_BEATS) : 4'd15;
      p.size = a.size;
      exp_aw.push_back(p);
      if (codes[i] > b.resp) b.resp = codes[i];
    end
    exp_b.push_back(b);
  endfunction

  task automatic make_bursts(output int total_beats);
    aw4_t       a;
    w4_beat_t   wb;
    w3_beat_t   eb;
    logic [1:0] codes [16];
    logic [2:0] r;
    total_beats = 0;
    for (int n = 0; n < N_BURSTS; n++) begin
      a.id   = ID_W'(rand_bits(ID_W));
      a.addr = (rand_bits(20) << 12) + (rand_bits(8) << 2);
      a.size = 3'(rand_bits(2) % 3);   // 1, 2 or 4 bytes
      a.len  = (n == 0) ? 8'd3 : (n == 1) ? 8'd15 : (n == 2) ? 8'd16 : 8'(rand_bits(8));
      for (int k = 0; k < 16; k++) begin
        r = 3'(rand_bits(3));
        codes[k] = (r == 3'd0) ? RESP_DECERR : (r == 3'd1) ? RESP_SLVERR : RESP_OKAY;
        if (k <= int'(a.len) / AXI3_MAX_BEATS) slave_codes.push_back(codes[k]);
      end
      build_expected(a, codes);
      aw_q.push_back(a);
      for (int i = 0; i <= int'(a.len); i++) begin
        wb.data = rand_bits(DATA_W);
        wb.strb = STRB_W'(rand_bits(STRB_W));
        wb.last = (i == int'(a.len));
        eb.id   = a.id;
        eb.data = wb.data;
        eb.strb = wb.strb;
        eb.last = wlast_at(i, int'(a.len));
        w_q.push_back(wb);
        exp_w.push_back(eb);
      end
      total_beats += int'(a.len) + 1;
    end
  endtask

  task automatic check_aw(input aw3_t got);
    aw3_t exp;
    if (exp_aw.size() == 0) begin
      other_errors++;
      $display("AXI3 AW issued with no piece left to expect");
    end else begin
      exp = exp_aw.pop_front();
      if (got !== exp) begin
        aw_errors++;
        $display("ERROR m_aw got %h expected %h", got, exp);
      end
    end
  endtask

  task automatic check_w(input w3_beat_t got);
    w3_beat_t exp;
    if (exp_w.size() == 0) begin
      other_errors++;
      $display("AXI3 W beat sent with no beat left to expect");
    end else begin
      exp = exp_w.pop_front();
      if (got !== exp) begin
        w_errors++;
        $display("ERROR m_w got %h expected %h", got, exp);
      end
    end
  endtask

  task automatic check_b(input b_resp_t got);
    b_resp_t exp;
    if (exp_b.size() == 0) begin
      other_errors++;
      $display("AXI4 B response returned with none expected");
    end else begin
      exp = exp_b.pop_front();
      if (got !== exp) begin
        b_errors++;
        $display("ERROR s_b got %h expected %h", got, exp);
      end
    end
  endtask

  // Master and slave side stimulus
  always @(negedge ACLK) begin
    if (drive_en) begin
      s_aw_valid <= (aw_q.size() > 0);
      if (aw_q.size() > 0) s_aw <= aw_q[0];
      s_w_valid  <= (w_q.size() > 0);
      if (w_q.size() > 0) s_w <= w_q[0];
      m_aw_ready <= (rand_bits(2) != 2'd0);
      m_w_ready  <= (rand_bits(2) != 2'd0);
      s_b_ready  <= (rand_bits(2) != 2'd0);
      // B only after the piece's W data is complete
      m_b_valid  <= (b_pend.size() > 0) && (wlast_seen > b_sent);
      if (b_pend.size() > 0) m_b <= b_pend[0];
    end
  end

  // Compare process and slave bookkeeping
  always @(posedge ACLK) begin
    if (ARESET || !drive_en) begin
      if (s_aw_ready | m_aw_valid | m_w_valid | s_w_ready | s_b_valid | m_b_ready) begin
        other_errors++;
        $display("A valid or ready output was active during or right after reset");
      end
    end else begin
      if (s_aw_valid && s_aw_ready) void'(aw_q.pop_front());
      if (s_w_valid && s_w_ready) void'(w_q.pop_front());
      if (m_aw_valid && m_aw_ready) begin
        check_aw(m_aw);
        slave_b.id   = m_aw.id;
        slave_b.resp = (slave_codes.size() > 0) ? slave_codes.pop_front() : RESP_OKAY;
        b_pend.push_back(slave_b);
      end
      if (m_w_valid && m_w_ready) begin
        check_w(m_w);
        if (m_w.last) wlast_seen++;
      end
      if (m_b_valid && m_b_ready) begin
        void'(b_pend.pop_front());
        b_sent++;
      end
      if (s_b_valid && s_b_ready) check_b(s_b);
    end
    cycle_cnt++;
    if (cycle_cnt > cycle_limit) begin
      $display("Run did not finish within %0d cycles", cycle_limit);
      $display("Simulation failed");
      $finish;
    end
  end

  initial begin
    int total_beats;
    s_aw         = '0;
    s_aw_valid   = 1'b0;
    m_aw_ready   = 1'b0;
    s_w          = '0;
    s_w_valid    = 1'b0;
    m_w_ready    = 1'b0;
    m_b          = '0;
    m_b_valid    = 1'b0;
    s_b_ready    = 1'b0;
    drive_en     = 1'b0;
    wlast_seen   = 0;
    b_sent       = 0;
    cycle_cnt    = 0;
    cycle_limit  = 1_000_000;
    aw_errors    = 0;
    w_errors     = 0;
    b_errors     = 0;
    other_errors = 0;
    lfsr_state   = 32'h6fab1fff;
    make_bursts(total_beats);
    cycle_limit = 40 * total_beats + 2000;
    @(negedge ARESET);
    @(posedge ACLK);   // first cycle after reset stays idle
    @(negedge ACLK);
    drive_en = 1'b1;
    while (aw_q.size() + w_q.size() + exp_aw.size() + exp_w.size() + exp_b.size() > 0) begin
      @(negedge ACLK);
    end
    repeat (20) @(negedge ACLK);
    $display("Errors: aw %0d, w %0d, b %0d, other %0d",
             aw_errors, w_errors, b_errors, other_errors);
    if (aw_errors + w_errors + b_errors + other_errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tb.f
source/axi3_conv_pkg.sv
source/aw_split_ctrl.sv
source/cmd_fifo.sv
source/w_axi3_conv.sv
source/b_merge.sv
source/axi3_write_conv.sv
verif/tb_clock_gen.sv
verif/axi3_write_conv_assert.sv
verif/tb_axi3_write_conv.sv

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f tb.f \
  --top-module tb_axi3_write_conv -o sim_tb || exit 1

out=$(./obj_dir/sim_tb)
echo "$out"
echo "$out" | grep -q "Simulation passed" && exit 0 || exit 1
